/* alu_apb.f */
rtl/alu_pkg.sv
rtl/apb_map_pkg.sv
rtl/alu_apb_regs.sv
rtl/alu_core.sv
rtl/alu_status.sv
rtl/alu_apb_top.sv
verif/alu_apb_props.sv
verif/alu_apb_tb.sv

/* Makefile */
TOP := alu_apb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f alu_apb.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* verif/alu_apb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_apb_tb;

	localparam int n_rand = 8;
	localparam int n_ops = 7 + n_rand * 8 + 3 + (n_rand / 2) * 5 + 9;
	localparam int limit_cycles = n_ops * 40 + 500;

	logic clk = 1'b0;
	logic reset;
	logic [apb_map_pkg::addr_w-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_map_pkg::pdata_w-1:0] pwdata;
	logic [apb_map_pkg::pdata_w-1:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] rng_state = 32'd31046;
	logic check_pending = 1'b0;
	string cur_name;
	logic [alu_pkg::data_w-1:0] exp_result;
	logic [alu_pkg::flag_w-1:0] exp_flag; // Model copy of the stored flag
	logic exp_branch;
	logic exp_stall;

	alu_apb_top UUT (.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr));

	always #10 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_result(input string name, input logic [alu_pkg::data_w-1:0] exp,
		input logic [alu_pkg::data_w-1:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic [alu_pkg::flag_w-1:0] exp,
		input logic [alu_pkg::flag_w-1:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic logic [31:0] rand32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic alu_pkg::instr_t enc_r(input logic [alu_pkg::func_w-1:0] fn);
		alu_pkg::instr_t ins;
		ins = '0;
		ins.r.opcode = alu_pkg::op_type_r;
		ins.r.func = fn;
		return ins;
	endfunction

	function automatic alu_pkg::instr_t enc_i(input logic [alu_pkg::op_w-1:0] op,
		input logic [alu_pkg::imm_w-1:0] imm);
		alu_pkg::instr_t ins;
		ins = '0;
		ins.i.opcode = op;
		ins.i.imm = imm;
		return ins;
	endfunction

	function automatic logic [2:0] range_flag(input longint v);
		if (v > 64'sd2147483647)
			return alu_pkg::flag_overflow;
		if (v < -64'sd2147483648)
			return alu_pkg::flag_underflow;
		return alu_pkg::flag_none;
	endfunction

	function automatic logic [2:0] compare_flag(input longint sa, input longint sb);
		if (sa == sb)
			return alu_pkg::flag_equal;
		if (sa > sb)
			return alu_pkg::flag_above;
		return alu_pkg::flag_none;
	endfunction

	function automatic logic [alu_pkg::data_w-1:0] model_op(input alu_pkg::instr_t ins,
		input logic [31:0] a, input logic [31:0] b_reg, input logic [2:0] flag_in,
		input logic branch_in, output logic [2:0] flag_out, output logic branch_out);
		logic [31:0] b;
		logic [31:0] res;
		longint sa;
		longint sb;
		b = {{16{ins.i.imm[15]}}, ins.i.imm};
		if (ins.i.opcode == alu_pkg::op_andi || ins.i.opcode == alu_pkg::op_ori)
			b = {16'h0000, ins.i.imm};
		else if (ins.r.opcode == alu_pkg::op_type_r)
			b = b_reg;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		res = '0;
		flag_out = flag_in;
		branch_out = branch_in;
		case (ins.r.opcode)
			alu_pkg::op_addi: begin
				res = a + b;
				flag_out = range_flag(sa + sb);
			end
			alu_pkg::op_subi: begin
				res = a - b;
				flag_out = range_flag(sa - sb);
			end
			alu_pkg::op_andi: res = a & b;
			alu_pkg::op_ori: res = a | b;
			alu_pkg::op_cmpi: flag_out = compare_flag(sa, sb);
			alu_pkg::op_brfl: begin
				res = a;
				branch_out = (flag_in == ins.i.imm[2:0]);
			end
			alu_pkg::op_type_r: begin
				case (ins.r.func)
					alu_pkg::fn_add: begin
						res = a + b;
						flag_out = range_flag(sa + sb);
					end
					alu_pkg::fn_sub: begin
						res = a - b;
						flag_out = range_flag(sa - sb);
					end
					alu_pkg::fn_mul: begin
						res = 32'(sa * sb);
						flag_out = range_flag(sa * sb);
					end
					alu_pkg::fn_div: begin
						if (b == '0) begin
							res = '1;
							flag_out = alu_pkg::flag_exception;
						end else begin
							res = 32'(sa / sb); // Truncates toward zero
							flag_out = alu_pkg::flag_none;
						end
					end
					alu_pkg::fn_and: res = a & b;
					alu_pkg::fn_or: res = a | b;
					alu_pkg::fn_not: res = ~b;
					alu_pkg::fn_cmp: flag_out = compare_flag(sa, sb);
					default: ;
				endcase
			end
			default: ;
		endcase
		return res;
	endfunction

	task automatic apb_write(input logic [apb_map_pkg::addr_w-1:0] addr,
		input logic [apb_map_pkg::pdata_w-1:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [apb_map_pkg::addr_w-1:0] addr,
		output logic [apb_map_pkg::pdata_w-1:0] data, output logic err, output int waits);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!pready) begin
			waits++;
			@(negedge clk);
		end
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic request_check(input string name);
		cur_name = name;
		check_pending = 1'b1;
		wait (!check_pending);
	endtask

	task automatic run_op(input string name, input alu_pkg::instr_t ins, input logic [31:0] a,
		input logic [31:0] b);
		logic err;
		logic [2:0] next_flag;
		logic next_branch;
		apb_write(apb_map_pkg::reg_op_a, a, err);
		check_bit({name, " op_a pslverr"}, 1'b0, err);
		apb_write(apb_map_pkg::reg_op_b, b, err);
		check_bit({name, " op_b pslverr"}, 1'b0, err);
		apb_write(apb_map_pkg::reg_instr, ins, err);
		check_bit({name, " instr pslverr"}, 1'b0, err);
		exp_result = model_op(ins, a, b, exp_flag, exp_branch, next_flag, next_branch);
		exp_flag = next_flag;
		exp_branch = next_branch;
		exp_stall = (ins.r.opcode == alu_pkg::op_type_r) && (ins.r.func == alu_pkg::fn_div);
		request_check(name);
	endtask

	// Reads result then status once per instruction
	initial begin : compare_proc
		logic [apb_map_pkg::pdata_w-1:0] rd;
		logic err;
		int waits;
		forever begin
			wait (check_pending);
			apb_read(apb_map_pkg::reg_result, rd, err, waits);
			check_bit({cur_name, " result pslverr"}, 1'b0, err);
			check_result({cur_name, " result"}, exp_result, rd);
			check_bit({cur_name, " result stall"}, exp_stall, waits > 1);
			apb_read(apb_map_pkg::reg_status, rd, err, waits);
			check_bit({cur_name, " status pslverr"}, 1'b0, err);
			check_flag({cur_name, " flag"}, exp_flag,
				rd[apb_map_pkg::st_flag_hi:apb_map_pkg::st_flag_lo]);
			check_bit({cur_name, " branch"}, exp_branch, rd[apb_map_pkg::st_branch]);
			check_bit({cur_name, " busy"}, 1'b0, rd[apb_map_pkg::st_busy]);
			check_pending = 1'b0;
		end
	end

	initial begin : watchdog
		repeat (limit_cycles) @(posedge clk);
		stop_with_failure($sformatf("timeout after %0d cycles, tests did not finish",
			limit_cycles));
	end

	initial begin : stimulus
		logic [31:0] a;
		logic [31:0] b;
		logic [apb_map_pkg::pdata_w-1:0] rd;
		logic err;
		int waits;
		int i;
		reset <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		repeat (4) @(posedge clk);
		reset <= 1'b1;
		exp_result = '0;
		exp_flag = alu_pkg::flag_none;
		exp_branch = 1'b0;
		exp_stall = 1'b0;
		request_check("reset");

		run_op("add ovf", enc_r(alu_pkg::fn_add), 32'h7fff_ffff, 32'h0000_0001);
		run_op("add unf", enc_r(alu_pkg::fn_add), 32'h8000_0000, 32'hffff_ffff);
		run_op("sub unf", enc_r(alu_pkg::fn_sub), 32'h8000_0000, 32'h0000_0001);
		run_op("subi ovf", enc_i(alu_pkg::op_subi, 16'hffff), 32'h7fff_ffff, '0);
		run_op("mul ovf", enc_r(alu_pkg::fn_mul), 32'h0001_0000, 32'h0001_0000);
		run_op("mul unf", enc_r(alu_pkg::fn_mul), 32'h0001_0000, 32'hffff_0000);
		for (i = 0; i < n_rand; i++) begin
			a = rand32();
			b = rand32();
			run_op("add", enc_r(alu_pkg::fn_add), a, b);
			run_op("sub", enc_r(alu_pkg::fn_sub), a, b);
			run_op("addi", enc_i(alu_pkg::op_addi, b[15:0]), a, b);
			run_op("subi", enc_i(alu_pkg::op_subi, b[31:16]), a, b);
			run_op("mul", enc_r(alu_pkg::fn_mul), a, b);
			run_op("mul small", enc_r(alu_pkg::fn_mul), a & 32'h0000_7fff, b | 32'hffff_8000);
			run_op("div", enc_r(alu_pkg::fn_div), a, b);
			run_op("div small", enc_r(alu_pkg::fn_div), a, {{12{b[31]}}, b[19:0]});
		end
		run_op("div zero", enc_r(alu_pkg::fn_div), 32'h1234_5678, '0);
		run_op("div zero neg", enc_r(alu_pkg::fn_div), 32'hfedc_ba98, '0);

		run_op("add flag set", enc_r(alu_pkg::fn_add), 32'h7fff_ffff, 32'h7fff_ffff);
		for (i = 0; i < n_rand / 2; i++) begin
			a = rand32();
			b = rand32();
			run_op("and", enc_r(alu_pkg::fn_and), a, b);
			run_op("or", enc_r(alu_pkg::fn_or), a, b);
			run_op("not", enc_r(alu_pkg::fn_not), a, b);
			run_op("andi", enc_i(alu_pkg::op_andi, b[15:0]), a, b);
			run_op("ori", enc_i(alu_pkg::op_ori, b[31:16]), a, b);
		end

		a = rand32();
		run_op("cmp equal", enc_r(alu_pkg::fn_cmp), a, a);
		run_op("brfl equal hit", enc_i(alu_pkg::op_brfl, 16'(alu_pkg::flag_equal)), a, '0);
		run_op("brfl above miss", enc_i(alu_pkg::op_brfl, 16'(alu_pkg::flag_above)), ~a, '0);
		run_op("cmpi above", enc_i(alu_pkg::op_cmpi, 16'h8000), 32'h0000_0001, '0);
		run_op("brfl above hit", enc_i(alu_pkg::op_brfl, 16'(alu_pkg::flag_above)), a, '0);
		run_op("cmp below", enc_r(alu_pkg::fn_cmp), 32'hffff_fff0, 32'h0000_0010);
		run_op("brfl none hit", enc_i(alu_pkg::op_brfl, 16'(alu_pkg::flag_none)),
			32'h1357_9bdf, '0);
		run_op("brfl equal miss", enc_i(alu_pkg::op_brfl, 16'(alu_pkg::flag_equal)), a, '0);

		apb_write(apb_map_pkg::reg_instr, enc_i(3'b111, 16'h0000), err); // Opcode 7
		check_bit("bad opcode pslverr", 1'b1, err);
		apb_write(apb_map_pkg::reg_instr, enc_r(6'h3f), err);
		check_bit("bad func pslverr", 1'b1, err);
		apb_write(8'h14, rand32(), err);
		check_bit("unmapped write pslverr", 1'b1, err);
		apb_read(8'h14, rd, err, waits);
		check_bit("unmapped read pslverr", 1'b1, err);
		exp_stall = 1'b0;
		request_check("after errors");

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/alu_apb_props.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_apb_props (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr,
	input wire logic start,
	input wire logic busy,
	input wire logic done
);

	logic pending;
	logic [5:0] wait_cnt;

	always_ff @(posedge clk) begin
		if (!reset) begin
			pending <= 1'b0;
			wait_cnt <= '0;
		end else if (start) begin
			pending <= 1'b1;
			wait_cnt <= 6'd1; // First cycle after start
		end else if (done) begin
			pending <= 1'b0;
		end else if (pending) begin
			wait_cnt <= wait_cnt + 6'd1;
		end
	end

	start_idle: assert property (@(posedge clk) disable iff (!reset) start |-> !busy)
		else $error("start issued while the core is busy");

	done_bound: assert property (@(posedge clk) disable iff (!reset)
		pending && !done |-> wait_cnt < 6'(alu_pkg::div_steps + 1))
		else $error("done did not follow start in time");

	err_no_start: assert property (@(posedge clk) disable iff (!reset)
		pslverr |=> !start)
		else $error("rejected transfer issued a start");

	reset_quiet: assert property (@(posedge clk) !reset |=> !start && !done && !busy)
		else $error("core control active during reset");

endmodule

bind alu_apb_top alu_apb_props u_props (
	.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
	.pslverr(pslverr), .start(start), .busy(core_busy), .done(done)
);

`default_nettype wire

/* rtl/alu_apb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_apb_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic [apb_map_pkg::addr_w-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [apb_map_pkg::pdata_w-1:0] pwdata,
	output logic [apb_map_pkg::pdata_w-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic start, core_busy, done, branch;
	logic [alu_pkg::data_w-1:0] operand_a, operand_b, result, last_result;
	logic [alu_pkg::op_w-1:0] opcode, done_opcode;
	logic [alu_pkg::func_w-1:0] func, done_func;
	logic [alu_pkg::flag_w-1:0] raw_flag, flag;

	alu_apb_regs u_regs (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.core_busy(core_busy), .last_result(last_result), .flag(flag), .branch(branch),
		.start(start), .operand_a(operand_a), .operand_b(operand_b),
		.opcode(opcode), .func(func)
	);

	alu_core u_core (
		.clk(clk), .reset(reset),
		.start(start), .operand_a(operand_a), .operand_b(operand_b),
		.opcode(opcode), .func(func),
		.busy(core_busy), .done(done), .result(result), .raw_flag(raw_flag),
		.done_opcode(done_opcode), .done_func(done_func)
	);

	alu_status u_status (
		.clk(clk), .reset(reset),
		.done(done), .done_opcode(done_opcode), .done_func(done_func),
		.result(result), .raw_flag(raw_flag),
		.last_result(last_result), .flag(flag), .branch(branch)
	);

endmodule

`default_nettype wire

/* rtl/alu_status.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_status (
	input wire logic clk,
	input wire logic reset,
	input wire logic done,
	input wire logic [alu_pkg::op_w-1:0] done_opcode,
	input wire logic [alu_pkg::func_w-1:0] done_func,
	input wire logic [alu_pkg::data_w-1:0] result,
	input wire logic [alu_pkg::flag_w-1:0] raw_flag,
	output logic [alu_pkg::data_w-1:0] last_result,
	output logic [alu_pkg::flag_w-1:0] flag,
	output logic branch
);

	logic flag_update;

	// Logic ops and BRFL keep the stored flag
	always_comb begin
		case (done_opcode)
			alu_pkg::op_addi, alu_pkg::op_subi, alu_pkg::op_cmpi: flag_update = 1'b1;
			alu_pkg::op_type_r: flag_update = !(done_func == alu_pkg::fn_and ||
				done_func == alu_pkg::fn_or || done_func == alu_pkg::fn_not);
			default: flag_update = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			last_result <= '0;
			flag <= alu_pkg::flag_none;
			branch <= 1'b0;
		end else if (done) begin
			last_result <= result;
			if (flag_update)
				flag <= raw_flag;
			// BRFL condition sits in imm[2:0], the same bits as func
			if (done_opcode == alu_pkg::op_brfl)
				branch <= (flag == done_func[alu_pkg::flag_w-1:0]);
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_core (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [alu_pkg::data_w-1:0] operand_a,
	input wire logic [alu_pkg::data_w-1:0] operand_b,
	input wire logic [alu_pkg::op_w-1:0] opcode,
	input wire logic [alu_pkg::func_w-1:0] func,
	output logic busy,
	output logic done,
	output logic [alu_pkg::data_w-1:0] result,
	output logic [alu_pkg::flag_w-1:0] raw_flag,
	output logic [alu_pkg::op_w-1:0] done_opcode,
	output logic [alu_pkg::func_w-1:0] done_func
);

	localparam int dw = alu_pkg::data_w;
	localparam int step_w = $clog2(alu_pkg::div_steps);

	logic [dw-1:0] sum, diff, alu_res, div_res, a_mag, b_mag;
	logic signed [2*dw-1:0] product;
	logic [alu_pkg::flag_w-1:0] alu_flag;
	logic is_div, div_run;
	logic [step_w-1:0] step_q;
	logic [dw-1:0] rem_q, quo_q, div_q, rem_next, quo_next;
	logic [dw:0] trial;
	logic div_neg_q, div_zero_q;

	// Signed overflow of a + b, with b already inverted for subtraction
	function automatic logic [alu_pkg::flag_w-1:0] ovf_flag(input logic a_s, input logic b_s,
		input logic r_s);
		if (a_s == b_s && r_s != a_s)
			return a_s ? alu_pkg::flag_underflow : alu_pkg::flag_overflow;
		return alu_pkg::flag_none;
	endfunction

	function automatic logic [alu_pkg::flag_w-1:0] cmp_flag(input logic [dw-1:0] a,
		input logic [dw-1:0] b);
		if (a == b)
			return alu_pkg::flag_equal;
		if ($signed(a) > $signed(b))
			return alu_pkg::flag_above;
		return alu_pkg::flag_none;
	endfunction

	assign sum = operand_a + operand_b;
	assign diff = operand_a - operand_b;
	assign product = $signed(operand_a) * $signed(operand_b);
	assign is_div = (opcode == alu_pkg::op_type_r) && (func == alu_pkg::fn_div);

	always_comb begin
		alu_res = '0;
		alu_flag = alu_pkg::flag_none;
		case (opcode)
			alu_pkg::op_addi: begin
				alu_res = sum;
				alu_flag = ovf_flag(operand_a[dw-1], operand_b[dw-1], sum[dw-1]);
			end
			alu_pkg::op_subi: begin
				alu_res = diff;
				alu_flag = ovf_flag(operand_a[dw-1], ~operand_b[dw-1], diff[dw-1]);
			end
			alu_pkg::op_andi: alu_res = operand_a & operand_b;
			alu_pkg::op_ori: alu_res = operand_a | operand_b;
			alu_pkg::op_brfl: alu_res = operand_a;
			alu_pkg::op_cmpi: alu_flag = cmp_flag(operand_a, operand_b);
			alu_pkg::op_type_r: begin
				case (func)
					alu_pkg::fn_add: begin
						alu_res = sum;
						alu_flag = ovf_flag(operand_a[dw-1], operand_b[dw-1], sum[dw-1]);
					end
					alu_pkg::fn_sub: begin
						alu_res = diff;
						alu_flag = ovf_flag(operand_a[dw-1], ~operand_b[dw-1], diff[dw-1]);
					end
					alu_pkg::fn_mul: begin
						alu_res = product[dw-1:0];
						if (product[2*dw-1:dw-1] != {(dw+1){product[dw-1]}})
							alu_flag = product[2*dw-1] ? alu_pkg::flag_underflow : alu_pkg::flag_overflow;
					end
					alu_pkg::fn_and: alu_res = operand_a & operand_b;
					alu_pkg::fn_or: alu_res = operand_a | operand_b;
					alu_pkg::fn_not: alu_res = ~operand_b;
					alu_pkg::fn_cmp: alu_flag = cmp_flag(operand_a, operand_b);
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	assign a_mag = operand_a[dw-1] ? -operand_a : operand_a;
	assign b_mag = operand_b[dw-1] ? -operand_b : operand_b;

	// One restoring step per cycle
	assign trial = {rem_q, quo_q[dw-1]} - {1'b0, div_q};
	assign rem_next = trial[dw] ? {rem_q[dw-2:0], quo_q[dw-1]} : trial[dw-1:0];
	assign quo_next = {quo_q[dw-2:0], ~trial[dw]};
	assign div_res = div_zero_q ? '1 : (div_neg_q ? -quo_next : quo_next);

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q <= '0;
			quo_q <= a_mag;
			div_q <= b_mag;
			div_neg_q <= operand_a[dw-1] ^ operand_b[dw-1];
			div_zero_q <= (operand_b == '0);
		end else if (div_run) begin
			rem_q <= rem_next;
			quo_q <= quo_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			div_run <= 1'b0;
			step_q <= '0;
			result <= '0;
			raw_flag <= alu_pkg::flag_none;
			done_opcode <= '0;
			done_func <= '0;
		end else begin
			done <= 1'b0;
			if (done)
				busy <= 1'b0; // Busy covers the done cycle
			if (start) begin
				busy <= 1'b1;
				done_opcode <= opcode;
				done_func <= func;
				if (is_div) begin
					div_run <= 1'b1;
					step_q <= '0;
				end else begin
					result <= alu_res;
					raw_flag <= alu_flag;
					done <= 1'b1;
				end
			end else if (div_run) begin
				step_q <= step_q + 1'b1;
				if (step_q == step_w'(alu_pkg::div_steps - 1)) begin
					div_run <= 1'b0;
					done <= 1'b1;
					result <= div_res;
					raw_flag <= div_zero_q ? alu_pkg::flag_exception : alu_pkg::flag_none;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_apb_regs (
	input wire logic clk,
	input wire logic reset,
	input wire logic [apb_map_pkg::addr_w-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [apb_map_pkg::pdata_w-1:0] pwdata,
	output logic [apb_map_pkg::pdata_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire logic core_busy,
	input wire logic [alu_pkg::data_w-1:0] last_result,
	input wire logic [alu_pkg::flag_w-1:0] flag,
	input wire logic branch,
	output logic start,
	output logic [alu_pkg::data_w-1:0] operand_a,
	output logic [alu_pkg::data_w-1:0] operand_b,
	output logic [alu_pkg::op_w-1:0] opcode,
	output logic [alu_pkg::func_w-1:0] func
);

	logic [alu_pkg::data_w-1:0] op_a_q;
	logic [alu_pkg::data_w-1:0] op_b_q;
	alu_pkg::instr_t instr_q;
	alu_pkg::instr_t wr_word;
	logic start_q;
	logic instr_ok;
	logic bus_err;
	logic access;
	logic xfer_ok;
	logic unit_busy;
	logic [alu_pkg::imm_w-1:0] imm;

	assign wr_word = pwdata;
	assign access = psel & penable;
	assign unit_busy = core_busy | start_q;

	always_comb begin
		instr_ok = 1'b1;
		if (wr_word.r.opcode == alu_pkg::op_type_r) begin
			case (wr_word.r.func)
				alu_pkg::fn_add, alu_pkg::fn_sub, alu_pkg::fn_mul, alu_pkg::fn_div,
				alu_pkg::fn_and, alu_pkg::fn_or, alu_pkg::fn_not, alu_pkg::fn_cmp:
					instr_ok = 1'b1;
				default: instr_ok = 1'b0;
			endcase
		end else if (&wr_word.i.opcode) begin
			instr_ok = 1'b0; // Opcode 7
		end
	end

	always_comb begin
		case (paddr)
			apb_map_pkg::reg_op_a, apb_map_pkg::reg_op_b: bus_err = 1'b0;
			apb_map_pkg::reg_instr: bus_err = pwrite & ~instr_ok;
			apb_map_pkg::reg_result, apb_map_pkg::reg_status: bus_err = pwrite; // Read only
			default: bus_err = 1'b1;
		endcase
	end

	// Instruction writes and result reads wait for the core
	assign pready = ~(psel & unit_busy & ((pwrite & (paddr == apb_map_pkg::reg_instr)) |
		(~pwrite & (paddr == apb_map_pkg::reg_result))));
	assign pslverr = access & pready & bus_err;
	assign xfer_ok = access & pready & ~bus_err;

	always_ff @(posedge clk) begin
		if (xfer_ok && pwrite) begin
			case (paddr)
				apb_map_pkg::reg_op_a: op_a_q <= pwdata;
				apb_map_pkg::reg_op_b: op_b_q <= pwdata;
				apb_map_pkg::reg_instr: instr_q <= wr_word;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			start_q <= 1'b0;
		end else begin
			start_q <= xfer_ok & pwrite & (paddr == apb_map_pkg::reg_instr);
		end
	end

	// ANDI and ORI take the immediate zero extended
	assign imm = instr_q.i.imm;
	always_comb begin
		case (instr_q.i.opcode)
			alu_pkg::op_type_r: operand_b = op_b_q;
			alu_pkg::op_andi, alu_pkg::op_ori: operand_b = {{(alu_pkg::data_w-alu_pkg::imm_w){1'b0}}, imm};
			default: operand_b = {{(alu_pkg::data_w-alu_pkg::imm_w){imm[alu_pkg::imm_w-1]}}, imm};
		endcase
	end

	assign start = start_q;
	assign operand_a = op_a_q;
	assign opcode = instr_q.r.opcode;
	assign func = instr_q.r.func; // Low imm bits for I-type

	always_comb begin
		prdata = '0;
		case (paddr)
			apb_map_pkg::reg_op_a: prdata = op_a_q;
			apb_map_pkg::reg_op_b: prdata = op_b_q;
			apb_map_pkg::reg_instr: prdata = instr_q;
			apb_map_pkg::reg_result: prdata = last_result;
			apb_map_pkg::reg_status: begin
				prdata[apb_map_pkg::st_flag_hi:apb_map_pkg::st_flag_lo] = flag;
				prdata[apb_map_pkg::st_branch] = branch;
				prdata[apb_map_pkg::st_busy] = unit_busy;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/apb_map_pkg.sv */
`default_nettype none

package apb_map_pkg;

	localparam int addr_w = 8;
	localparam int pdata_w = 32;

	localparam logic [addr_w-1:0] reg_op_a = 8'h00;
	localparam logic [addr_w-1:0] reg_op_b = 8'h04;
	localparam logic [addr_w-1:0] reg_instr = 8'h08;
	localparam logic [addr_w-1:0] reg_result = 8'h0C;
	localparam logic [addr_w-1:0] reg_status = 8'h10;

	localparam int st_flag_lo = 0;
	localparam int st_flag_hi = 2;
	localparam int st_branch = 3;
	localparam int st_busy = 4;

endpackage

`default_nettype wire

/* rtl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	localparam int data_w = 32;
	localparam int div_steps = 32;
	localparam int op_w = 3;
	localparam int func_w = 6;
	localparam int imm_w = 16;
	localparam int flag_w = 3;

	localparam logic [op_w-1:0] op_addi = 3'b000;
	localparam logic [op_w-1:0] op_subi = 3'b001;
	localparam logic [op_w-1:0] op_type_r = 3'b010;
	localparam logic [op_w-1:0] op_andi = 3'b011;
	localparam logic [op_w-1:0] op_ori = 3'b100;
	localparam logic [op_w-1:0] op_brfl = 3'b101;
	localparam logic [op_w-1:0] op_cmpi = 3'b110; // 3'b111 is invalid

	localparam logic [func_w-1:0] fn_add = 6'b100000;
	localparam logic [func_w-1:0] fn_sub = 6'b100010;
	localparam logic [func_w-1:0] fn_mul = 6'b000010;
	localparam logic [func_w-1:0] fn_div = 6'b000001;
	localparam logic [func_w-1:0] fn_and = 6'b100100;
	localparam logic [func_w-1:0] fn_or = 6'b100101;
	localparam logic [func_w-1:0] fn_not = 6'b100111;
	localparam logic [func_w-1:0] fn_cmp = 6'b101010;

	localparam logic [flag_w-1:0] flag_none = 3'd0;
	localparam logic [flag_w-1:0] flag_equal = 3'd1;
	localparam logic [flag_w-1:0] flag_exception = 3'd2;
	localparam logic [flag_w-1:0] flag_overflow = 3'd3;
	localparam logic [flag_w-1:0] flag_underflow = 3'd4;
	localparam logic [flag_w-1:0] flag_above = 3'd5;

	typedef union packed {
		struct packed {
			logic [op_w-1:0] opcode;
			logic [data_w-op_w-func_w-1:0] rsvd;
			logic [func_w-1:0] func;
		} r; // R-type view
		struct packed {
			logic [op_w-1:0] opcode;
			logic [data_w-op_w-imm_w-1:0] rsvd;
			logic [imm_w-1:0] imm;
		} i; // I-type view
	} instr_t;

endpackage

`default_nettype wire
